// File: regblk_pkg.sv
`default_nettype none

package regblk_pkg;

  localparam int ADDR_W = 8;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // axi response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;
  localparam logic [1:0] RESP_DECERR = 2'b11;

  // register byte offsets
  localparam logic [ADDR_W-1:0] OFS_CTRL   = 8'h00;
  localparam logic [ADDR_W-1:0] OFS_LOAD   = 8'h04;
  localparam logic [ADDR_W-1:0] OFS_COUNT  = 8'h08;
  localparam logic [ADDR_W-1:0] OFS_STATUS = 8'h0C;
  localparam logic [ADDR_W-1:0] OFS_ID     = 8'h10;

  typedef struct packed {logic valid; logic [ADDR_W-1:0] addr;} axil_aw_t;

  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } axil_w_t;

  typedef struct packed {logic valid; logic [ADDR_W-1:0] addr;} axil_ar_t;

  typedef struct packed {
    logic       valid;
    logic [1:0] resp;
  } axil_b_t;

  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] data;
    logic [1:0]        resp;
  } axil_r_t;

  // single-beat access on the internal register bus
  typedef struct packed {
    logic              valid;
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] strb;
  } reg_req_t;

  typedef struct packed {
    logic              ready;
    logic [DATA_W-1:0] rdata;
    logic [1:0]        status;
  } reg_rsp_t;

  // one-hot register select, at most one bit set
  typedef struct packed {
    logic id;
    logic status;
    logic count;
    logic load;
    logic ctrl;
  } reg_sel_t;

endpackage

`default_nettype wire

// File: axil_adapter.sv
`timescale 1ns/10ps
`default_nettype none

module axil_adapter #(
  parameter bit WRITE_FIRST = 1'b1
) (
  input  wire                   i_clk,
  input  wire                   i_rst_n,
  input  regblk_pkg::axil_aw_t  i_aw,
  input  regblk_pkg::axil_w_t   i_w,
  input  regblk_pkg::axil_ar_t  i_ar,
  output logic                  o_awready,
  output logic                  o_wready,
  output logic                  o_arready,
  output regblk_pkg::axil_b_t   o_b,
  input  wire                   i_bready,
  output regblk_pkg::axil_r_t   o_r,
  input  wire                   i_rready,
  output regblk_pkg::reg_req_t  o_req,
  input  regblk_pkg::reg_rsp_t  i_rsp
);

  typedef enum logic {
    IDLE,
    RESPOND
  } state_t;

  state_t state;

  logic write_pend;
  logic read_pend;
  logic write_win;
  logic read_win;
  logic accept;
  logic resp_ack;

  logic                          resp_write;
  logic [regblk_pkg::DATA_W-1:0] resp_data;
  logic [1:0]                    resp_status;

  // a write needs aw and w together
  assign write_pend = i_aw.valid && i_w.valid;
  assign read_pend  = i_ar.valid;

  always_comb begin
    write_win = 1'b0;
    read_win  = 1'b0;
    if (state == IDLE) begin
      if (WRITE_FIRST) begin
        write_win = write_pend;
        read_win  = read_pend && !write_pend;
      end else begin
        read_win  = read_pend;
        write_win = write_pend && !read_pend;
      end
    end
  end

  assign o_awready = write_win;
  assign o_wready  = write_win;
  assign o_arready = read_win;

  // request goes straight out from the winning channel
  assign o_req.valid = write_win || read_win;
  assign o_req.write = write_win;
  assign o_req.addr  = write_win ? i_aw.addr : i_ar.addr;
  assign o_req.wdata = i_w.data;
  assign o_req.strb  = write_win ? i_w.strb : '0;

  assign accept   = o_req.valid && i_rsp.ready;
  assign resp_ack = (o_b.valid && i_bready) || (o_r.valid && i_rready);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state      <= IDLE;
      resp_write <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (accept) begin
            state      <= RESPOND;
            resp_write <= o_req.write;
          end
        end
        RESPOND: begin
          if (resp_ack) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // answer of the register bus, held until the master takes it
  always_ff @(posedge i_clk) begin
    if (accept) begin
      resp_data   <= i_rsp.rdata;
      resp_status <= i_rsp.status;
    end
  end

  assign o_b.valid = (state == RESPOND) && resp_write;
  assign o_b.resp  = resp_status;

  assign o_r.valid = (state == RESPOND) && !resp_write;
  assign o_r.data  = resp_data;
  assign o_r.resp  = resp_status;

  a_one_response: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(o_b.valid && o_r.valid));

  // stalled response keeps its payload and blocks new requests
  a_b_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_b.valid && !i_bready) |=> (o_b.valid && $stable(o_b.resp) && !o_arready));

  a_r_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_r.valid && !i_rready) |=> (o_r.valid && $stable(o_r.data) && $stable(o_r.resp)
      && !o_awready));

endmodule

`default_nettype wire

// File: reg_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module reg_decoder (
  input  regblk_pkg::reg_req_t           i_req,
  output regblk_pkg::reg_sel_t           o_sel,
  input  wire [regblk_pkg::DATA_W-1:0]   i_rdata,
  input  wire [1:0]                      i_status,
  output regblk_pkg::reg_rsp_t           o_rsp
);

  logic [regblk_pkg::ADDR_W-3:0] word_addr;
  logic                          hit;

  // byte lanes inside a word are ignored
  assign word_addr = i_req.addr[regblk_pkg::ADDR_W-1:2];

  always_comb begin
    o_sel = '0;
    if (i_req.valid) begin
      o_sel.ctrl   = (word_addr == regblk_pkg::OFS_CTRL[regblk_pkg::ADDR_W-1:2]);
      o_sel.load   = (word_addr == regblk_pkg::OFS_LOAD[regblk_pkg::ADDR_W-1:2]);
      o_sel.count  = (word_addr == regblk_pkg::OFS_COUNT[regblk_pkg::ADDR_W-1:2]);
      o_sel.status = (word_addr == regblk_pkg::OFS_STATUS[regblk_pkg::ADDR_W-1:2]);
      o_sel.id     = (word_addr == regblk_pkg::OFS_ID[regblk_pkg::ADDR_W-1:2]);
    end
  end

  assign hit = |o_sel;

  // no wait states on this bus
  assign o_rsp.ready  = 1'b1;
  assign o_rsp.rdata  = hit ? i_rdata : '0;
  assign o_rsp.status = hit ? i_status : regblk_pkg::RESP_DECERR;

  always_comb begin
    a_sel_onehot: assert ($onehot0(o_sel))
      else $error("register select not one-hot: %b", o_sel);
  end

endmodule

`default_nettype wire

// File: ctrl_regs.sv
`timescale 1ns/10ps
`default_nettype none

module ctrl_regs #(
  parameter logic [regblk_pkg::DATA_W-1:0] ID_VALUE = 32'h5247_4231
) (
  input  wire                            i_clk,
  input  wire                            i_rst_n,
  input  regblk_pkg::reg_req_t           i_req,
  input  regblk_pkg::reg_sel_t           i_sel,
  output logic [regblk_pkg::DATA_W-1:0]  o_rdata,
  output logic [1:0]                     o_status,
  output logic                           o_enable,
  output logic                           o_auto_reload,
  output logic [regblk_pkg::DATA_W-1:0]  o_load_value,
  output logic                           o_start,
  input  wire [regblk_pkg::DATA_W-1:0]   i_count,
  input  wire                            i_expire,
  output logic                           o_expired
);

  logic                          wr;
  logic [1:0]                    ctrl_q;
  logic [regblk_pkg::DATA_W-1:0] load_q;
  logic                          expired_q;

  assign wr = i_req.valid && i_req.write;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ctrl_q    <= '0;
      load_q    <= '0;
      expired_q <= 1'b0;
    end else begin
      if (wr && i_sel.ctrl && i_req.strb[0]) begin
        ctrl_q <= i_req.wdata[1:0];
      end
      for (int b = 0; b < regblk_pkg::STRB_W; b++) begin
        if (wr && i_sel.load && i_req.strb[b]) begin
          load_q[8*b +: 8] <= i_req.wdata[8*b +: 8];
        end
      end
      // set wins over a clear in the same cycle
      if (i_expire) begin
        expired_q <= 1'b1;
      end else if (wr && i_sel.status && i_req.strb[0] && i_req.wdata[0]) begin
        expired_q <= 1'b0;
      end
    end
  end

  // rising edge of enable restarts the timer from LOAD
  assign o_start = wr && i_sel.ctrl && i_req.strb[0] && i_req.wdata[0] && !ctrl_q[0];

  always_comb begin
    o_rdata = '0;
    if (i_sel.ctrl)   o_rdata[1:0] = ctrl_q;
    if (i_sel.load)   o_rdata      = load_q;
    if (i_sel.count)  o_rdata      = i_count;
    if (i_sel.status) o_rdata[0]   = expired_q;
    if (i_sel.id)     o_rdata      = ID_VALUE;
  end

  // COUNT and ID are read-only
  assign o_status = (wr && (i_sel.count || i_sel.id)) ? regblk_pkg::RESP_SLVERR
                                                      : regblk_pkg::RESP_OKAY;

  assign o_enable      = ctrl_q[0];
  assign o_auto_reload = ctrl_q[1];
  assign o_load_value  = load_q;
  assign o_expired     = expired_q;

  // the timer only flags expiry once its count sits at zero
  a_expire_at_zero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_expire |-> (i_count == '0));

endmodule

`default_nettype wire

// File: interval_timer.sv
`timescale 1ns/10ps
`default_nettype none

module interval_timer (
  input  wire                            i_clk,
  input  wire                            i_rst_n,
  input  wire                            i_enable,
  input  wire                            i_auto_reload,
  input  wire [regblk_pkg::DATA_W-1:0]   i_load_value,
  input  wire                            i_start,
  output logic [regblk_pkg::DATA_W-1:0]  o_count,
  output logic                           o_expire
);

  logic [regblk_pkg::DATA_W-1:0] count_q;
  logic                          expire_q;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      count_q  <= '0;
      expire_q <= 1'b0;
    end else begin
      if (i_start) begin
        count_q <= i_load_value;
      end else if (i_enable) begin
        if (count_q != '0) begin
          count_q <= count_q - 1'b1;
        end else if (i_auto_reload) begin
          count_q <= i_load_value;
        end
      end
      // pulse on the step from one to zero only
      expire_q <= i_enable && !i_start && (count_q == 1);
    end
  end

  assign o_count  = count_q;
  assign o_expire = expire_q;

endmodule

`default_nettype wire

// File: regblk_top.sv
`timescale 1ns/10ps
`default_nettype none

module regblk_top #(
  parameter bit                            WRITE_FIRST = 1'b1,
  parameter logic [regblk_pkg::DATA_W-1:0] ID_VALUE    = 32'h5247_4231
) (
  input  wire                   i_clk,
  input  wire                   i_rst_n,
  input  regblk_pkg::axil_aw_t  i_aw,
  input  regblk_pkg::axil_w_t   i_w,
  input  regblk_pkg::axil_ar_t  i_ar,
  output logic                  o_awready,
  output logic                  o_wready,
  output logic                  o_arready,
  output regblk_pkg::axil_b_t   o_b,
  input  wire                   i_bready,
  output regblk_pkg::axil_r_t   o_r,
  input  wire                   i_rready,
  output logic                  o_expired
);

  regblk_pkg::reg_req_t          req;
  regblk_pkg::reg_rsp_t          rsp;
  regblk_pkg::reg_sel_t          sel;
  logic [regblk_pkg::DATA_W-1:0] rdata;
  logic [1:0]                    status;
  logic                          enable;
  logic                          auto_reload;
  logic [regblk_pkg::DATA_W-1:0] load_value;
  logic                          start;
  logic [regblk_pkg::DATA_W-1:0] count;
  logic                          expire;

  axil_adapter #(.WRITE_FIRST(WRITE_FIRST)) u_adapter (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_aw      (i_aw),
    .i_w       (i_w),
    .i_ar      (i_ar),
    .o_awready (o_awready),
    .o_wready  (o_wready),
    .o_arready (o_arready),
    .o_b       (o_b),
    .i_bready  (i_bready),
    .o_r       (o_r),
    .i_rready  (i_rready),
    .o_req     (req),
    .i_rsp     (rsp)
  );

  reg_decoder u_decoder (
    .i_req    (req),
    .o_sel    (sel),
    .i_rdata  (rdata),
    .i_status (status),
    .o_rsp    (rsp)
  );

  ctrl_regs #(.ID_VALUE(ID_VALUE)) u_regs (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_req         (req),
    .i_sel         (sel),
    .o_rdata       (rdata),
    .o_status      (status),
    .o_enable      (enable),
    .o_auto_reload (auto_reload),
    .o_load_value  (load_value),
    .o_start       (start),
    .i_count       (count),
    .i_expire      (expire),
    .o_expired     (o_expired)
  );

  interval_timer u_timer (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_enable      (enable),
    .i_auto_reload (auto_reload),
    .i_load_value  (load_value),
    .i_start       (start),
    .o_count       (count),
    .o_expire      (expire)
  );

endmodule

`default_nettype wire

// File: tb_regblk.sv
`timescale 1ns/10ps
`default_nettype none

module tb_regblk;

  localparam int CLK_PERIOD  = 100;
  localparam int MAX_TXN     = 200;
  localparam int CYC_PER_TXN = 10;
  localparam logic [regblk_pkg::DATA_W-1:0] ID_EXP = 32'h5247_4231;

  logic                          i_clk;
  logic                          i_rst_n;
  regblk_pkg::axil_aw_t          aw;
  regblk_pkg::axil_w_t           w;
  regblk_pkg::axil_ar_t          ar;
  logic                          awready;
  logic                          wready;
  logic                          arready;
  regblk_pkg::axil_b_t           b;
  regblk_pkg::axil_r_t           r;
  logic                          bready;
  logic                          rready;
  logic                          expired;

  integer                        seed;
  int                            checks;
  int                            errors;
  int                            start;
  logic [regblk_pkg::ADDR_W-1:0] addr;
  logic [regblk_pkg::DATA_W-1:0] data;
  logic [regblk_pkg::DATA_W-1:0] rd;
  logic [regblk_pkg::DATA_W-1:0] rd2;
  logic [regblk_pkg::DATA_W-1:0] load;
  logic [regblk_pkg::STRB_W-1:0] strb;
  logic [1:0]                    resp;

  // register model
  logic [1:0]                    ctrl_m;
  logic [regblk_pkg::DATA_W-1:0] load_m;
  logic                          expired_m;

  regblk_top #(.WRITE_FIRST(1'b1), .ID_VALUE(ID_EXP)) u_regblk_top (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_aw      (aw),
    .i_w       (w),
    .i_ar      (ar),
    .o_awready (awready),
    .o_wready  (wready),
    .o_arready (arready),
    .o_b       (b),
    .i_bready  (bready),
    .o_r       (r),
    .i_rready  (rready),
    .o_expired (expired)
  );

  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  initial begin
    #(MAX_TXN * CYC_PER_TXN * CLK_PERIOD);
    $display("run timed out after %0d cycles without finishing", MAX_TXN * CYC_PER_TXN);
    $display("CHECKS FAILED");
    $finish;
  end

  task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error at %0d ns: %s expected %0d, got %0d", $time, name, exp, act);
    end
  endtask

  task automatic check_data(input string name, input logic [regblk_pkg::DATA_W-1:0] exp,
                            input logic [regblk_pkg::DATA_W-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error at %0d ns: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error at %0d ns: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  task automatic report_test(input string name, input int err_start);
    if (errors == err_start) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - err_start);
    end
  endtask

  task automatic apply_write(input logic [regblk_pkg::ADDR_W-1:0] a,
                             input logic [regblk_pkg::DATA_W-1:0] d,
                             input logic [regblk_pkg::STRB_W-1:0] s);
    if (a == regblk_pkg::OFS_CTRL && s[0]) begin
      ctrl_m = d[1:0];
    end
    for (int i = 0; i < regblk_pkg::STRB_W; i++) begin
      if (a == regblk_pkg::OFS_LOAD && s[i]) begin
        load_m[8*i +: 8] = d[8*i +: 8];
      end
    end
    if (a == regblk_pkg::OFS_STATUS && s[0] && d[0]) begin
      expired_m = 1'b0;
    end
  endtask

  // ready held low for 0..3 cycles with all request channels kept busy
  // so the response has to stay put and nothing may be accepted
  task automatic take_response(input logic is_write, output logic [1:0] rsp,
                               output logic [regblk_pkg::DATA_W-1:0] rdata);
    int                            stall;
    logic [regblk_pkg::DATA_W-1:0] junk;
    stall = $unsigned($random(seed)) % 4;
    for (int i = 0; i <= stall; i++) begin
      if (i > 0) begin
        @(negedge i_clk);
      end
      if (i < stall) begin
        junk     = $random(seed);
        aw.addr  = junk[7:0];
        ar.addr  = junk[15:8];
        w.data   = junk;
        w.strb   = '1;
        aw.valid = 1'b1;
        w.valid  = 1'b1;
        ar.valid = 1'b1;
      end else begin
        aw.valid = 1'b0;
        w.valid  = 1'b0;
        ar.valid = 1'b0;
        bready   = is_write;
        rready   = !is_write;
      end
      #10;
      check_flag("o_b.valid", is_write, b.valid);
      check_flag("o_r.valid", !is_write, r.valid);
      if (i == 0) begin
        rsp   = is_write ? b.resp : r.resp;
        rdata = r.data;
      end else if (is_write) begin
        check_resp("o_b.resp", rsp, b.resp);
      end else begin
        check_resp("o_r.resp", rsp, r.resp);
        check_data("o_r.data", rdata, r.data);
      end
      check_flag("o_awready", 1'b0, awready);
      check_flag("o_wready", 1'b0, wready);
      check_flag("o_arready", 1'b0, arready);
    end
    @(negedge i_clk);
    bready = 1'b0;
    rready = 1'b0;
  endtask

  task automatic axil_write(input logic [regblk_pkg::ADDR_W-1:0] a,
                            input logic [regblk_pkg::DATA_W-1:0] d,
                            input logic [regblk_pkg::STRB_W-1:0] s, output logic [1:0] rsp);
    logic                          got;
    logic [regblk_pkg::DATA_W-1:0] unused;
    @(negedge i_clk);
    aw.addr  = a;
    w.data   = d;
    w.strb   = s;
    aw.valid = 1'b1;
    w.valid  = 1'b1;
    got      = 1'b0;
    while (!got) begin
      #10;
      got = awready && wready;
      @(negedge i_clk);
    end
    aw.valid = 1'b0;
    w.valid  = 1'b0;
    take_response(1'b1, rsp, unused);
  endtask

  task automatic axil_read(input logic [regblk_pkg::ADDR_W-1:0] a,
                           output logic [regblk_pkg::DATA_W-1:0] d, output logic [1:0] rsp);
    logic got;
    @(negedge i_clk);
    ar.addr  = a;
    ar.valid = 1'b1;
    got      = 1'b0;
    while (!got) begin
      #10;
      got = arready;
      @(negedge i_clk);
    end
    ar.valid = 1'b0;
    take_response(1'b0, rsp, d);
  endtask

  function automatic logic [regblk_pkg::DATA_W-1:0] model_read(
      input logic [regblk_pkg::ADDR_W-1:0] a);
    if (a == regblk_pkg::OFS_LOAD) begin
      return load_m;
    end
    return {30'b0, ctrl_m};
  endfunction

  initial begin
    seed      = 65;
    checks    = 0;
    errors    = 0;
    ctrl_m    = '0;
    load_m    = '0;
    expired_m = 1'b0;
    i_clk     = 1'b0;
    i_rst_n   = 1'b0;
    aw        = '0;
    w         = '0;
    ar        = '0;
    bready    = 1'b0;
    rready    = 1'b0;
    repeat (5) @(negedge i_clk);
    i_rst_n = 1'b1;

    start = errors;
    for (int n = 0; n < 40; n++) begin
      data = $random(seed);
      addr = data[0] ? regblk_pkg::OFS_LOAD : regblk_pkg::OFS_CTRL;
      data = $random(seed);
      strb = data[31:28];
      axil_write(addr, data, strb, resp);
      check_resp("o_b.resp", regblk_pkg::RESP_OKAY, resp);
      apply_write(addr, data, strb);
      axil_read(addr, rd, resp);
      check_resp("o_r.resp", regblk_pkg::RESP_OKAY, resp);
      check_data("o_r.data", model_read(addr), rd);
    end
    report_test("random CTRL and LOAD access", start);

    start = errors;
    for (int n = 0; n < 4; n++) begin
      addr = n[0] ? regblk_pkg::OFS_ID : regblk_pkg::OFS_COUNT;
      data = $random(seed);
      axil_write(addr, data, data[3:0], resp);
      check_resp("o_b.resp", regblk_pkg::RESP_SLVERR, resp);
    end
    axil_read(regblk_pkg::OFS_CTRL, rd, resp);
    check_data("o_r.data", model_read(regblk_pkg::OFS_CTRL), rd);
    axil_read(regblk_pkg::OFS_LOAD, rd, resp);
    check_data("o_r.data", model_read(regblk_pkg::OFS_LOAD), rd);
    axil_read(regblk_pkg::OFS_ID, rd, resp);
    check_resp("o_r.resp", regblk_pkg::RESP_OKAY, resp);
    check_data("o_r.data", ID_EXP, rd);
    report_test("read-only registers", start);

    start = errors;
    for (int n = 0; n < 10; n++) begin
      // word addresses from above ID to the top of the map
      addr = 8'h14 + ($unsigned($random(seed)) % 236);
      data = $random(seed);
      axil_write(addr, data, 4'hF, resp);
      check_resp("o_b.resp", regblk_pkg::RESP_DECERR, resp);
      axil_read(addr, rd, resp);
      check_resp("o_r.resp", regblk_pkg::RESP_DECERR, resp);
      check_data("o_r.data", '0, rd);
    end
    report_test("unmapped addresses", start);

    start = errors;
    load = 5 + ($unsigned($random(seed)) % 6);
    axil_write(regblk_pkg::OFS_CTRL, 32'h0, 4'hF, resp);
    apply_write(regblk_pkg::OFS_CTRL, 32'h0, 4'hF);
    axil_write(regblk_pkg::OFS_LOAD, load, 4'hF, resp);
    apply_write(regblk_pkg::OFS_LOAD, load, 4'hF);
    axil_write(regblk_pkg::OFS_STATUS, 32'h1, 4'h1, resp);
    apply_write(regblk_pkg::OFS_STATUS, 32'h1, 4'h1);
    axil_read(regblk_pkg::OFS_STATUS, rd, resp);
    check_flag("STATUS.expired", expired_m, rd[0]);
    axil_write(regblk_pkg::OFS_CTRL, 32'h1, 4'hF, resp);
    apply_write(regblk_pkg::OFS_CTRL, 32'h1, 4'hF);
    repeat (load + 4) @(negedge i_clk);
    expired_m = 1'b1;
    axil_read(regblk_pkg::OFS_STATUS, rd, resp);
    check_flag("STATUS.expired", expired_m, rd[0]);
    check_flag("o_expired", expired_m, expired);
    axil_read(regblk_pkg::OFS_COUNT, rd, resp);
    check_data("o_r.data", '0, rd);
    axil_write(regblk_pkg::OFS_STATUS, 32'h1, 4'h1, resp);
    check_resp("o_b.resp", regblk_pkg::RESP_OKAY, resp);
    apply_write(regblk_pkg::OFS_STATUS, 32'h1, 4'h1);
    axil_read(regblk_pkg::OFS_STATUS, rd, resp);
    check_flag("STATUS.expired", expired_m, rd[0]);
    report_test("one-shot expiry", start);

    start = errors;
    for (int n = 0; n < 6; n++) begin
      data = $random(seed);
      axil_write(regblk_pkg::OFS_LOAD, data, 4'hF, resp);
      apply_write(regblk_pkg::OFS_LOAD, data, 4'hF);
      axil_read(regblk_pkg::OFS_LOAD, rd, resp);
      check_data("o_r.data", load_m, rd);
    end
    report_test("back-pressure", start);

    start = errors;
    load = 3 + ($unsigned($random(seed)) % 5);
    axil_write(regblk_pkg::OFS_CTRL, 32'h0, 4'hF, resp);
    axil_write(regblk_pkg::OFS_LOAD, load, 4'hF, resp);
    axil_write(regblk_pkg::OFS_CTRL, 32'h3, 4'hF, resp);
    for (int n = 0; n < 8; n++) begin
      axil_read(regblk_pkg::OFS_COUNT, rd, resp);
      check_flag("o_r.data <= LOAD", 1'b1, rd <= load);
    end
    axil_write(regblk_pkg::OFS_CTRL, 32'h0, 4'hF, resp);
    axil_read(regblk_pkg::OFS_COUNT, rd, resp);
    axil_read(regblk_pkg::OFS_COUNT, rd2, resp);
    check_data("o_r.data", rd, rd2);
    report_test("auto-reload", start);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
regblk_pkg.sv
axil_adapter.sv
reg_decoder.sv
ctrl_regs.sv
interval_timer.sv
regblk_top.sv
tb_regblk.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_regblk -f all.f -o tb_regblk
./obj_dir/tb_regblk | tee sim.log
if grep -q "ALL CHECKS PASSED" sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1
